// ==== include/cmp_rs_defines.svh ====
`ifndef CMP_RS_DEFINES_SVH
`define CMP_RS_DEFINES_SVH

// RV32I operand width
`define CMP_RS_XLEN 32

// reorder buffer index width
`define CMP_RS_TAG_W 4

// entries held by the station
`define CMP_RS_SIZE 4

// external CDB ports snooped for operands
// the station's own write port is not counted
`define CMP_RS_CDB_PORTS 2

`endif

// ==== source/cmp_rs_pkg.sv ====
package cmp_rs_pkg;

    // comparison opcodes in a private encoding
    typedef enum logic [2:0] {
        // equal
        CMP_EQ  = 3'd0,
        // not equal
        CMP_NE  = 3'd1,
        // signed less than
        CMP_LT  = 3'd2,
        // signed greater or equal
        CMP_GE  = 3'd3,
        // unsigned less than
        CMP_LTU = 3'd4,
        // unsigned greater or equal
        CMP_GEU = 3'd5
    } cmp_op_e;

    // lifecycle of one station slot
    typedef enum logic [1:0] {
        // slot empty
        ST_FREE = 2'd0,
        // operands pending or compare in flight
        ST_WAIT = 2'd1,
        // result held until broadcast
        ST_DONE = 2'd2
    } entry_state_e;

endpackage

// ==== source/cmp_rs_cmp.sv ====
`timescale 1ns/1ps
`include "cmp_rs_defines.svh"

module cmp_rs_cmp import cmp_rs_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    start_i,
    input  cmp_op_e                 op_i,
    input  logic [`CMP_RS_XLEN-1:0] a_i,
    input  logic [`CMP_RS_XLEN-1:0] b_i,
    output logic                    result_o,
    output logic                    done_o
);

    logic outcome;

    // relation selected by the opcode
    always_comb begin
        case (op_i)
            CMP_EQ:  outcome = (a_i == b_i);
            CMP_NE:  outcome = (a_i != b_i);
            CMP_LT:  outcome = ($signed(a_i) < $signed(b_i));
            CMP_GE:  outcome = ($signed(a_i) >= $signed(b_i));
            CMP_LTU: outcome = (a_i < b_i);
            CMP_GEU: outcome = (a_i >= b_i);
            // unused encodings read as false
            default: outcome = 1'b0;
        endcase
    end

    // done follows start by one edge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

    // outcome held until the next start
    always_ff @(posedge clk) begin
        if (start_i) begin
            result_o <= outcome;
        end
    end

endmodule

// ==== source/cmp_rs_alloc.sv ====
`timescale 1ns/1ps
`include "cmp_rs_defines.svh"

module cmp_rs_alloc (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    flush_i,
    input  logic                    dispatch_valid_i,
    input  logic [`CMP_RS_SIZE-1:0] free_mask_i,
    output logic [`CMP_RS_SIZE-1:0] alloc_onehot_o,
    output logic                    full_o
);

    logic [`CMP_RS_SIZE-1:0] pick;
    logic                    found;
    logic                    accept;
    logic                    full_next;

    // lowest free slot wins
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < `CMP_RS_SIZE; i++) begin
            if (free_mask_i[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    // dispatch dropped while full
    assign accept         = dispatch_valid_i & ~full_o;
    assign alloc_onehot_o = accept ? pick : '0;

    // occupied after the edge if not free now or taken now
    // free_mask_i already counts slots released this cycle
    assign full_next = &(~free_mask_i | alloc_onehot_o);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_o <= 1'b0;
        end else if (flush_i) begin
            full_o <= 1'b0;
        end else begin
            full_o <= full_next;
        end
    end

endmodule

// ==== source/cmp_rs_entries.sv ====
`timescale 1ns/1ps
`include "cmp_rs_defines.svh"

module cmp_rs_entries import cmp_rs_pkg::*; (
    input  logic                                              clk,
    input  logic                                              arst_n_i,
    input  logic                                              flush_i,
    input  logic [`CMP_RS_SIZE-1:0]                           alloc_onehot_i,
    input  cmp_op_e                                           dispatch_op_i,
    input  logic [`CMP_RS_TAG_W-1:0]                          dispatch_dest_i,
    input  logic                                              dispatch_rs1_rdy_i,
    input  logic [`CMP_RS_XLEN-1:0]                           dispatch_rs1_val_i,
    input  logic [`CMP_RS_TAG_W-1:0]                          dispatch_rs1_tag_i,
    input  logic                                              dispatch_rs2_rdy_i,
    input  logic [`CMP_RS_XLEN-1:0]                           dispatch_rs2_val_i,
    input  logic [`CMP_RS_TAG_W-1:0]                          dispatch_rs2_tag_i,
    input  logic [`CMP_RS_CDB_PORTS-1:0]                      cdb_valid_i,
    input  logic [`CMP_RS_CDB_PORTS-1:0][`CMP_RS_TAG_W-1:0]   cdb_tag_i,
    input  logic [`CMP_RS_CDB_PORTS-1:0][`CMP_RS_XLEN-1:0]    cdb_value_i,
    input  logic [`CMP_RS_SIZE-1:0]                           release_onehot_i,
    output logic [`CMP_RS_SIZE-1:0]                           free_mask_o,
    output logic [`CMP_RS_SIZE-1:0]                           done_mask_o,
    output logic [`CMP_RS_SIZE-1:0][`CMP_RS_TAG_W-1:0]        entry_dest_o,
    output logic [`CMP_RS_SIZE-1:0]                           entry_result_o
);

    // control state
    entry_state_e                           state_q [`CMP_RS_SIZE];
    logic [`CMP_RS_SIZE-1:0]                rs1_rdy_q;
    logic [`CMP_RS_SIZE-1:0]                rs2_rdy_q;
    logic [`CMP_RS_SIZE-1:0]                issued_q;
    logic [`CMP_RS_SIZE-1:0]                start_q;
    // payload
    cmp_op_e                                op_q [`CMP_RS_SIZE];
    logic [`CMP_RS_SIZE-1:0][`CMP_RS_TAG_W-1:0] dest_q;
    logic [`CMP_RS_SIZE-1:0][`CMP_RS_TAG_W-1:0] rs1_tag_q;
    logic [`CMP_RS_SIZE-1:0][`CMP_RS_TAG_W-1:0] rs2_tag_q;
    logic [`CMP_RS_SIZE-1:0][`CMP_RS_XLEN-1:0]  rs1_val_q;
    logic [`CMP_RS_SIZE-1:0][`CMP_RS_XLEN-1:0]  rs2_val_q;
    logic [`CMP_RS_SIZE-1:0]                result_q;
    // per-entry wakeup and issue
    logic [`CMP_RS_SIZE-1:0]                rs1_wake;
    logic [`CMP_RS_SIZE-1:0]                rs2_wake;
    logic [`CMP_RS_SIZE-1:0]                issue_go;
    logic [`CMP_RS_SIZE-1:0]                cmp_done;
    logic [`CMP_RS_SIZE-1:0]                cmp_res;
    logic [`CMP_RS_SIZE-1:0]                finish;
    // dispatch side capture
    logic                                   disp_rs1_hit;
    logic                                   disp_rs2_hit;

    // any valid CDB port carrying this tag
    function automatic logic cdb_hit(input logic [`CMP_RS_TAG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `CMP_RS_CDB_PORTS; p++) begin
            if (cdb_valid_i[p] && cdb_tag_i[p] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // value from the lowest matching port
    function automatic logic [`CMP_RS_XLEN-1:0] cdb_val(input logic [`CMP_RS_TAG_W-1:0] tag);
        logic [`CMP_RS_XLEN-1:0] val;
        logic                    hit;
        val = '0;
        hit = 1'b0;
        for (int p = 0; p < `CMP_RS_CDB_PORTS; p++) begin
            if (cdb_valid_i[p] && cdb_tag_i[p] == tag && !hit) begin
                val = cdb_value_i[p];
                hit = 1'b1;
            end
        end
        return val;
    endfunction

    // operand broadcast in the dispatch cycle
    assign disp_rs1_hit = cdb_hit(dispatch_rs1_tag_i);
    assign disp_rs2_hit = cdb_hit(dispatch_rs2_tag_i);

    for (genvar i = 0; i < `CMP_RS_SIZE; i++) begin : g_entry
        // snoop only while waiting on a tag
        assign rs1_wake[i] = (state_q[i] == ST_WAIT) && !rs1_rdy_q[i] && cdb_hit(rs1_tag_q[i]);
        assign rs2_wake[i] = (state_q[i] == ST_WAIT) && !rs2_rdy_q[i] && cdb_hit(rs2_tag_q[i]);
        // one start per instruction
        assign issue_go[i] = (state_q[i] == ST_WAIT) && rs1_rdy_q[i] && rs2_rdy_q[i]
                             && !issued_q[i];
        // done from a stale compare is ignored by a fresh entry
        assign finish[i] = (state_q[i] == ST_WAIT) && issued_q[i] && cmp_done[i];

        assign free_mask_o[i] = (state_q[i] == ST_FREE) || release_onehot_i[i];
        assign done_mask_o[i] = (state_q[i] == ST_DONE);

        cmp_rs_cmp u_cmp (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .start_i  (start_q[i]),
            .op_i     (op_q[i]),
            .a_i      (rs1_val_q[i]),
            .b_i      (rs2_val_q[i]),
            .result_o (cmp_res[i]),
            .done_o   (cmp_done[i])
        );
    end

    assign entry_dest_o   = dest_q;
    assign entry_result_o = result_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CMP_RS_SIZE; i++) begin
                state_q[i] <= ST_FREE;
            end
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            issued_q  <= '0;
            start_q   <= '0;
        end else if (flush_i) begin
            for (int i = 0; i < `CMP_RS_SIZE; i++) begin
                state_q[i] <= ST_FREE;
            end
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            issued_q  <= '0;
            start_q   <= '0;
        end else begin
            start_q <= issue_go;
            for (int i = 0; i < `CMP_RS_SIZE; i++) begin
                if (alloc_onehot_i[i]) begin
                    // load wins over a release in the same cycle
                    state_q[i]   <= ST_WAIT;
                    rs1_rdy_q[i] <= dispatch_rs1_rdy_i | disp_rs1_hit;
                    rs2_rdy_q[i] <= dispatch_rs2_rdy_i | disp_rs2_hit;
                    issued_q[i]  <= 1'b0;
                end else begin
                    if (release_onehot_i[i]) begin
                        state_q[i] <= ST_FREE;
                    end else if (finish[i]) begin
                        state_q[i] <= ST_DONE;
                    end
                    if (issue_go[i]) begin
                        issued_q[i] <= 1'b1;
                    end
                    if (rs1_wake[i]) begin
                        rs1_rdy_q[i] <= 1'b1;
                    end
                    if (rs2_wake[i]) begin
                        rs2_rdy_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CMP_RS_SIZE; i++) begin
            if (alloc_onehot_i[i]) begin
                op_q[i]      <= dispatch_op_i;
                dest_q[i]    <= dispatch_dest_i;
                rs1_tag_q[i] <= dispatch_rs1_tag_i;
                rs2_tag_q[i] <= dispatch_rs2_tag_i;
                // ready value or else whatever the CDB carries now
                rs1_val_q[i] <= dispatch_rs1_rdy_i ? dispatch_rs1_val_i
                                                   : cdb_val(dispatch_rs1_tag_i);
                rs2_val_q[i] <= dispatch_rs2_rdy_i ? dispatch_rs2_val_i
                                                   : cdb_val(dispatch_rs2_tag_i);
            end else begin
                if (rs1_wake[i]) begin
                    rs1_val_q[i] <= cdb_val(rs1_tag_q[i]);
                end
                if (rs2_wake[i]) begin
                    rs2_val_q[i] <= cdb_val(rs2_tag_q[i]);
                end
            end
            // latch outcome as the entry goes done
            if (finish[i]) begin
                result_q[i] <= cmp_res[i];
            end
        end
    end

endmodule

// ==== source/cmp_rs_bcast.sv ====
`timescale 1ns/1ps
`include "cmp_rs_defines.svh"

module cmp_rs_bcast (
    input  logic                                       clk,
    input  logic                                       arst_n_i,
    input  logic                                       flush_i,
    input  logic [`CMP_RS_SIZE-1:0]                    done_mask_i,
    input  logic [`CMP_RS_SIZE-1:0][`CMP_RS_TAG_W-1:0] entry_dest_i,
    input  logic [`CMP_RS_SIZE-1:0]                    entry_result_i,
    output logic [`CMP_RS_SIZE-1:0]                    release_onehot_o,
    output logic                                       result_valid_o,
    output logic [`CMP_RS_TAG_W-1:0]                   result_tag_o,
    output logic [`CMP_RS_XLEN-1:0]                    result_value_o
);

    localparam int IDX_W = $clog2(`CMP_RS_SIZE);

    logic [`CMP_RS_SIZE-1:0] sel;
    logic [IDX_W-1:0]        sel_idx;
    logic                    any_done;

    // fixed priority with the lowest finished entry first
    always_comb begin
        sel      = '0;
        sel_idx  = '0;
        any_done = 1'b0;
        for (int i = 0; i < `CMP_RS_SIZE; i++) begin
            if (done_mask_i[i] && !any_done) begin
                sel[i]   = 1'b1;
                sel_idx  = IDX_W'(i);
                any_done = 1'b1;
            end
        end
    end

    // winner is freed at the same edge its result is registered
    assign release_onehot_o = sel;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
        end else if (flush_i) begin
            // squashed work is never broadcast
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= any_done;
        end
    end

    // write port payload with the compare bit zero extended
    always_ff @(posedge clk) begin
        if (any_done) begin
            result_tag_o   <= entry_dest_i[sel_idx];
            result_value_o <= {{(`CMP_RS_XLEN-1){1'b0}}, entry_result_i[sel_idx]};
        end
    end

endmodule

// ==== source/cmp_rs_top.sv ====
`timescale 1ns/1ps
`include "cmp_rs_defines.svh"

module cmp_rs_top import cmp_rs_pkg::*; (
    input  logic                                            clk,
    input  logic                                            arst_n_i,
    input  logic                                            flush_i,
    input  logic                                            dispatch_valid_i,
    input  cmp_op_e                                         dispatch_op_i,
    input  logic [`CMP_RS_TAG_W-1:0]                        dispatch_dest_i,
    input  logic                                            dispatch_rs1_rdy_i,
    input  logic [`CMP_RS_XLEN-1:0]                         dispatch_rs1_val_i,
    input  logic [`CMP_RS_TAG_W-1:0]                        dispatch_rs1_tag_i,
    input  logic                                            dispatch_rs2_rdy_i,
    input  logic [`CMP_RS_XLEN-1:0]                         dispatch_rs2_val_i,
    input  logic [`CMP_RS_TAG_W-1:0]                        dispatch_rs2_tag_i,
    input  logic [`CMP_RS_CDB_PORTS-1:0]                    cdb_valid_i,
    input  logic [`CMP_RS_CDB_PORTS-1:0][`CMP_RS_TAG_W-1:0] cdb_tag_i,
    input  logic [`CMP_RS_CDB_PORTS-1:0][`CMP_RS_XLEN-1:0]  cdb_value_i,
    output logic                                            full_o,
    output logic                                            result_valid_o,
    output logic [`CMP_RS_TAG_W-1:0]                        result_tag_o,
    output logic [`CMP_RS_XLEN-1:0]                         result_value_o
);

    logic [`CMP_RS_SIZE-1:0]                    free_mask;
    logic [`CMP_RS_SIZE-1:0]                    alloc_onehot;
    logic [`CMP_RS_SIZE-1:0]                    done_mask;
    logic [`CMP_RS_SIZE-1:0]                    release_onehot;
    logic [`CMP_RS_SIZE-1:0][`CMP_RS_TAG_W-1:0] entry_dest;
    logic [`CMP_RS_SIZE-1:0]                    entry_result;

    // slot selection and full level
    cmp_rs_alloc u_alloc (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .free_mask_i      (free_mask),
        .alloc_onehot_o   (alloc_onehot),
        .full_o           (full_o)
    );

    // storage, wakeup and comparators
    cmp_rs_entries u_entries (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .flush_i            (flush_i),
        .alloc_onehot_i     (alloc_onehot),
        .dispatch_op_i      (dispatch_op_i),
        .dispatch_dest_i    (dispatch_dest_i),
        .dispatch_rs1_rdy_i (dispatch_rs1_rdy_i),
        .dispatch_rs1_val_i (dispatch_rs1_val_i),
        .dispatch_rs1_tag_i (dispatch_rs1_tag_i),
        .dispatch_rs2_rdy_i (dispatch_rs2_rdy_i),
        .dispatch_rs2_val_i (dispatch_rs2_val_i),
        .dispatch_rs2_tag_i (dispatch_rs2_tag_i),
        .cdb_valid_i        (cdb_valid_i),
        .cdb_tag_i          (cdb_tag_i),
        .cdb_value_i        (cdb_value_i),
        .release_onehot_i   (release_onehot),
        .free_mask_o        (free_mask),
        .done_mask_o        (done_mask),
        .entry_dest_o       (entry_dest),
        .entry_result_o     (entry_result)
    );

    // CDB write port
    cmp_rs_bcast u_bcast (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .done_mask_i      (done_mask),
        .entry_dest_i     (entry_dest),
        .entry_result_i   (entry_result),
        .release_onehot_o (release_onehot),
        .result_valid_o   (result_valid_o),
        .result_tag_o     (result_tag_o),
        .result_value_o   (result_value_o)
    );

endmodule

// ==== dv/cmp_rs_tb.sv ====
`timescale 1ns/1ps
`include "cmp_rs_defines.svh"

module cmp_rs_tb import cmp_rs_pkg::*; ();

    localparam int XL = `CMP_RS_XLEN;
    localparam int TW = `CMP_RS_TAG_W;
    localparam int NTAGS = 2 ** `CMP_RS_TAG_W;
    localparam int LIMIT = 200;

    logic                                clk;
    logic                                arst_n_i;
    logic                                flush_i;
    logic                                dispatch_valid_i;
    cmp_op_e                             dispatch_op_i;
    logic [TW-1:0]                       dispatch_dest_i;
    logic                                dispatch_rs1_rdy_i;
    logic [XL-1:0]                       dispatch_rs1_val_i;
    logic [TW-1:0]                       dispatch_rs1_tag_i;
    logic                                dispatch_rs2_rdy_i;
    logic [XL-1:0]                       dispatch_rs2_val_i;
    logic [TW-1:0]                       dispatch_rs2_tag_i;
    logic [`CMP_RS_CDB_PORTS-1:0]        cdb_valid_i;
    logic [`CMP_RS_CDB_PORTS-1:0][TW-1:0] cdb_tag_i;
    logic [`CMP_RS_CDB_PORTS-1:0][XL-1:0] cdb_value_i;
    logic                                full_o;
    logic                                result_valid_o;
    logic [TW-1:0]                       result_tag_o;
    logic [XL-1:0]                       result_value_o;

    int errors;
    int checks;
    int seed;
    // model of outstanding (tag, value) pairs
    logic [TW-1:0] exp_tag [$];
    logic [XL-1:0] exp_val [$];
    // per dest tag whether it waits on a producer or was flushed
    logic          blocked   [NTAGS];
    logic [TW-1:0] block_src [NTAGS];
    logic          squashed  [NTAGS];
    logic [XL-1:0] edge_a [5];
    logic [XL-1:0] edge_b [5];
    logic [XL-1:0] held   [4];

    cmp_rs_top dut (.*);

    always #20 clk = ~clk;

    // flush leaves no broadcast and no full level behind
    assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(flush_i) |-> (!result_valid_o && !full_o))
    else begin
        $display("broadcast or full level seen right after a flush at %0t", $time);
        errors++;
    end

    // write port carries a single compare bit
    assert property (@(posedge clk) disable iff (!arst_n_i)
        result_valid_o |-> (result_value_o[XL-1:1] == '0))
    else begin
        $display("** Error at %0t: result_value_o expected 0 or 1 got %0h", $time,
                 result_value_o);
        errors++;
    end

    // signed and unsigned order straight from the opcode definitions
    function automatic logic ref_cmp(input cmp_op_e op, input logic [XL-1:0] a,
                                     input logic [XL-1:0] b);
        logic [XL-1:0] a_off;
        logic [XL-1:0] b_off;
        logic          res;
        // sign bit flipped turns signed order into unsigned order
        a_off = {~a[XL-1], a[XL-2:0]};
        b_off = {~b[XL-1], b[XL-2:0]};
        case (op)
            CMP_EQ:  res = (a == b);
            CMP_NE:  res = !(a == b);
            CMP_LT:  res = (a_off < b_off);
            CMP_GE:  res = !(a_off < b_off);
            CMP_LTU: res = (a < b);
            CMP_GEU: res = !(a < b);
            default: res = 1'b0;
        endcase
        return res;
    endfunction

    function automatic cmp_op_e rand_op();
        int r;
        r = $unsigned($random(seed)) % 6;
        return cmp_op_e'(r[2:0]);
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        errors++;
        finish_run();
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s expected %0b got %0b", $time, name, exp, got);
            errors++;
        end
    endtask

    // one broadcast against the model
    task automatic check_result(input logic [TW-1:0] tag, input logic [XL-1:0] val);
        int idx;
        idx = -1;
        foreach (exp_tag[i]) begin
            if (exp_tag[i] == tag && idx < 0) begin
                idx = i;
            end
        end
        checks++;
        assert (!squashed[tag]) else begin
            $display("flushed or dropped tag %0d was broadcast at %0t", tag, $time);
            errors++;
        end
        assert (!blocked[tag]) else begin
            $display("tag %0d broadcast at %0t before its operand was on the CDB", tag, $time);
            errors++;
        end
        assert (idx >= 0) else begin
            $display("tag %0d broadcast at %0t was not outstanding", tag, $time);
            errors++;
        end
        if (idx >= 0) begin
            assert (val == exp_val[idx]) else begin
                $display("** Error at %0t: result_value_o for tag %0d expected %0h got %0h",
                         $time, tag, exp_val[idx], val);
                errors++;
            end
            exp_tag.delete(idx);
            exp_val.delete(idx);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n_i && result_valid_o) begin
            check_result(result_tag_o, result_value_o);
        end
    end

    task automatic dispatch(input cmp_op_e op, input logic [TW-1:0] dest,
                            input logic r1, input logic [XL-1:0] v1, input logic [TW-1:0] t1,
                            input logic r2, input logic [XL-1:0] v2, input logic [TW-1:0] t2);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (full_o) begin
            if (cnt == LIMIT) abort_on_timeout("a free entry");
            cnt++;
            @(negedge clk);
        end
        @(posedge clk);
        dispatch_valid_i   <= 1'b1;
        dispatch_op_i      <= op;
        dispatch_dest_i    <= dest;
        dispatch_rs1_rdy_i <= r1;
        dispatch_rs1_tag_i <= t1;
        dispatch_rs2_rdy_i <= r2;
        dispatch_rs2_tag_i <= t2;
        // junk on a waiting operand so only the CDB value can count
        dispatch_rs1_val_i <= r1 ? v1 : ~v1;
        dispatch_rs2_val_i <= r2 ? v2 : ~v2;
        exp_tag.push_back(dest);
        exp_val.push_back(XL'(ref_cmp(op, v1, v2)));
        squashed[dest]  = 1'b0;
        blocked[dest]   = !(r1 && r2);
        block_src[dest] = r1 ? t2 : t1;
        @(posedge clk);
        dispatch_valid_i <= 1'b0;
    endtask

    // one producer result on an external CDB port
    task automatic cdb_send(input int port, input logic [TW-1:0] tag, input logic [XL-1:0] value);
        @(posedge clk);
        cdb_valid_i[port] <= 1'b1;
        cdb_tag_i[port]   <= tag;
        cdb_value_i[port] <= value;
        for (int t = 0; t < NTAGS; t++) begin
            if (block_src[t] == tag) begin
                blocked[t] = 1'b0;
            end
        end
        @(posedge clk);
        cdb_valid_i <= '0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        @(posedge clk);
        while (exp_tag.size() != 0) begin
            if (cnt == LIMIT) abort_on_timeout("all outstanding results");
            cnt++;
            @(posedge clk);
        end
    endtask

    initial begin
        logic [XL-1:0] va;
        logic [XL-1:0] vb;
        int            cnt;
        seed   = 70;
        errors = 0;
        checks = 0;
        clk = 1'b0;
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_op_i = CMP_EQ;
        dispatch_dest_i = '0;
        dispatch_rs1_rdy_i = 1'b0;
        dispatch_rs1_val_i = '0;
        dispatch_rs1_tag_i = '0;
        dispatch_rs2_rdy_i = 1'b0;
        dispatch_rs2_val_i = '0;
        dispatch_rs2_tag_i = '0;
        cdb_valid_i = '0;
        cdb_tag_i = '0;
        cdb_value_i = '0;
        for (int t = 0; t < NTAGS; t++) begin
            blocked[t]   = 1'b0;
            block_src[t] = '0;
            squashed[t]  = 1'b0;
        end
        // equal values and sign boundaries
        edge_a = '{32'd5, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0};
        edge_b = '{32'd5, 32'h8000_0000, 32'h7fff_ffff, 32'h0, 32'hffff_ffff};
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;

        @(negedge clk);
        check_level("full_o", full_o, 1'b0);
        check_level("result_valid_o", result_valid_o, 1'b0);

        // every opcode with ready operands
        for (int o = 0; o < 6; o++) begin
            for (int k = 0; k < 7; k++) begin
                if (k < 5) begin
                    va = edge_a[k];
                    vb = edge_b[k];
                end else begin
                    va = $random(seed);
                    vb = $random(seed);
                end
                dispatch(cmp_op_e'(o[2:0]), TW'(o * 7 + k), 1'b1, va, '0, 1'b1, vb, '0);
            end
        end
        wait_drain();

        // rs1 waits on tag 13 until the CDB delivers it
        va = $random(seed);
        vb = $random(seed);
        dispatch(CMP_LTU, TW'(3), 1'b0, va, TW'(13), 1'b1, vb, '0);
        repeat (10) @(posedge clk);
        cdb_send(1, TW'(13), va);
        wait_drain();

        // fill all four entries with waiting work
        for (int e = 0; e < 4; e++) begin
            va = $random(seed);
            vb = $random(seed);
            held[e] = va;
            dispatch(rand_op(), TW'(e), 1'b0, va, TW'(8 + e), 1'b1, vb, '0);
        end
        @(negedge clk);
        check_level("full_o", full_o, 1'b1);
        // dispatch while full is dropped
        @(posedge clk);
        dispatch_valid_i   <= 1'b1;
        dispatch_dest_i    <= TW'(15);
        dispatch_rs1_rdy_i <= 1'b1;
        dispatch_rs2_rdy_i <= 1'b1;
        squashed[15] = 1'b1;
        @(posedge clk);
        dispatch_valid_i <= 1'b0;
        cdb_send(0, TW'(8), held[0]);
        cnt = 0;
        @(negedge clk);
        while (full_o) begin
            if (cnt == LIMIT) abort_on_timeout("full_o to drop");
            cnt++;
            @(negedge clk);
        end
        for (int e = 1; e < 4; e++) begin
            cdb_send(e % 2, TW'(8 + e), held[e]);
        end
        wait_drain();

        // one shared producer wakes all four at once
        vb = $random(seed);
        for (int e = 0; e < 4; e++) begin
            va = $random(seed);
            dispatch(rand_op(), TW'(e), 1'b1, va, '0, 1'b0, vb, TW'(14));
        end
        cdb_send(0, TW'(14), vb);
        wait_drain();

        // flush with all four entries still waiting on tag 12
        for (int e = 0; e < 4; e++) begin
            va = $random(seed);
            vb = $random(seed);
            dispatch(rand_op(), TW'(4 + e), 1'b0, va, TW'(12), 1'b1, vb, '0);
        end
        @(negedge clk);
        check_level("full_o", full_o, 1'b1);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        // squashed work leaves the model
        exp_tag.delete();
        exp_val.delete();
        for (int e = 4; e < 8; e++) begin
            squashed[e] = 1'b1;
        end
        @(negedge clk);
        check_level("full_o", full_o, 1'b0);
        cdb_send(1, TW'(12), va);
        repeat (10) @(posedge clk);

        finish_run();
    end

endmodule

// ==== cmp_rs.f ====
+incdir+include
source/cmp_rs_pkg.sv
source/cmp_rs_cmp.sv
source/cmp_rs_alloc.sv
source/cmp_rs_entries.sv
source/cmp_rs_bcast.sv
source/cmp_rs_top.sv
dv/cmp_rs_tb.sv

// ==== Makefile ====
TOP = cmp_rs_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f cmp_rs.f --top-module cmp_rs_top

sim:
	verilator --binary --timing --assert -f cmp_rs.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
